// ==== hps_audio.f ====
source/hps_audio_pkg.sv
source/host_cmd_decoder.sv
source/audio_channel_mixer.sv
source/hps_audio_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_hps_audio.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hps_audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_hps_audio \
	--Mdir obj_dir \
	-o tb_hps_audio \
	-f hps_audio.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_hps_audio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== source/audio_channel_mixer.sv ====
/*
 * one audio channel mixer
 * filters the core sample for stability, adds host PCM, blends the other
 * channel, then attenuates and clamps to 16 bits
 */
`timescale 1ns/1ps
`default_nettype none

module audio_channel_mixer #(
	parameter int STABLE_DEPTH = hps_audio_pkg::STABLE_DEPTH_DEFAULT
) (
	input  wire                             clk,
	input  wire                             resetd,
	input  wire  hps_audio_pkg::audio_cfg_t i_cfg,
	input  wire  hps_audio_pkg::sample_t    i_core,
	input  wire  hps_audio_pkg::sample_t    i_pcm,
	input  wire  hps_audio_pkg::sample_t    i_pre_other,
	output hps_audio_pkg::sample_t          o_pre,
	output hps_audio_pkg::sample_t          o_audio
);

	import hps_audio_pkg::*;

	sample_t      core_sr [0:STABLE_DEPTH-1];
	logic         core_stable;
	sample_t      core_take;
	wide_sample_t conv_val;
	wide_sample_t pcm_w;
	wide_sample_t other_w;
	wide_sample_t mix_val;
	wide_sample_t att_val;
	sample_t      clamp_val;

	wide_sample_t conv_q;
	wide_sample_t sum_q;
	sample_t      pre_q;
	wide_sample_t mix_q;
	wide_sample_t att_q;
	sample_t      out_q;

	//////////////////////////////////////////////////
	// stage 0/1: stability filter and conversion
	//////////////////////////////////////////////////

	// core sample must sit unchanged in every shift stage
	always_comb begin
		core_stable = 1'b1;
		for (int i = 1; i < STABLE_DEPTH; i++) begin
			if (core_sr[i] != core_sr[0]) begin
				core_stable = 1'b0;
			end
		end
	end

	assign core_take = core_sr[STABLE_DEPTH-1];

	// unsigned audio is halved so it fits below the sign bit
	assign conv_val = i_cfg.core_signed ? {core_take[15], core_take}
	                                    : {2'b00, core_take[15:1]};

	//////////////////////////////////////////////////
	// stage 2/3: PCM sum and stereo blend
	//////////////////////////////////////////////////

	assign pcm_w   = {i_pcm[15], i_pcm};
	assign other_w = {i_pre_other[15], i_pre_other};

	always_comb begin
		case (i_cfg.mix)
			mix_light:  mix_val = sum_q - (sum_q >>> 3) + (other_w >>> 2);
			mix_medium: mix_val = sum_q - (sum_q >>> 2) + (other_w >>> 1);
			mix_mono:   mix_val = (sum_q >>> 1) + other_w;
			default:    mix_val = sum_q;
		endcase
	end

	//////////////////////////////////////////////////
	// stage 4/5: attenuation and clamp
	//////////////////////////////////////////////////

	// both arms signed so the shift stays arithmetic
	assign att_val = i_cfg.att[4] ? wide_sample_t'('0) : (mix_q >>> i_cfg.att[3:0]);

	// saturate when the guard bit disagrees with bit 15
	always_comb begin
		if (att_q[16] != att_q[15]) begin
			clamp_val = {att_q[16], {15{~att_q[16]}}};
		end else begin
			clamp_val = att_q[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_sr <= '{default: '0};
			conv_q  <= '0;
			sum_q   <= '0;
			pre_q   <= '0;
			mix_q   <= '0;
			att_q   <= '0;
			out_q   <= '0;
		end else begin
			core_sr[0] <= i_core;
			for (int i = 1; i < STABLE_DEPTH; i++) begin
				core_sr[i] <= core_sr[i-1];
			end
			// conversion stage holds its value while the core input settles
			if (core_stable) begin
				conv_q <= conv_val;
			end
			sum_q <= conv_q + pcm_w;
			pre_q <= sum_q[16:1];
			mix_q <= mix_val;
			att_q <= att_val;
			out_q <= clamp_val;
		end
	end

	assign o_pre   = pre_q;
	assign o_audio = out_q;

	// attenuation and clamp keep the sign of the blended value
	property p_clamp_sign;
		@(posedge clk) disable iff (resetd)
		!$past(i_cfg.att[4], 2) |-> o_audio[15] == $past(mix_q[16], 2);
	endproperty
	a_clamp_sign: assert property (p_clamp_sign)
		else $error("output sign differs from the blended value");

endmodule

`default_nettype wire

// ==== source/host_cmd_decoder.sv ====
/*
 * host command decoder
 * acknowledges host strobe toggles, tracks the command of each session
 * and holds the volume attenuation register
 */
`timescale 1ns/1ps
`default_nettype none

module host_cmd_decoder (
	input  wire                            clk,
	input  wire                            resetd,
	input  wire  hps_audio_pkg::host_bus_t i_host,
	output logic                           o_ack,
	output hps_audio_pkg::vol_att_t        o_vol_att
);

	import hps_audio_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_cmd,
		st_data
	} dec_state_t;

	logic       strobe_q;
	logic       sel_q;
	host_word_t data_q;
	logic       ack_q;
	logic       word_stb;
	host_cmd_t  cmd_q;
	dec_state_t state;
	vol_att_t   vol_att_q;

	//////////////////////////////////////////////////
	// strobe capture and acknowledge
	//////////////////////////////////////////////////

	// ack is the strobe level delayed by two registers
	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_q <= 1'b0;
			sel_q    <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			strobe_q <= i_host.strobe;
			sel_q    <= i_host.sel;
			ack_q    <= strobe_q;
		end
	end

	// host keeps the word steady until ack matches, so no reset needed
	always_ff @(posedge clk) begin
		data_q <= i_host.data;
	end

	// rising strobe edge, seen one stage before ack catches up
	assign word_stb = strobe_q & ~ack_q;

	assign o_ack = ack_q;

	//////////////////////////////////////////////////
	// session FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state     <= st_idle;
			cmd_q     <= '0;
			vol_att_q <= '0;
		end else if (!sel_q) begin
			// dropping select ends the session
			state <= st_idle;
		end else if (word_stb) begin
			case (state)
				st_idle: begin
					cmd_q <= data_q[7:0];
					state <= st_cmd;
				end
				st_cmd,
				st_data: begin
					if (cmd_q == CMD_VOLUME) begin
						vol_att_q <= data_q[4:0];
					end
					state <= st_data;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign o_vol_att = vol_att_q;

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// every acknowledged word inside a session is taken by the FSM
	property p_ack_consumes_word;
		@(posedge clk) disable iff (resetd)
		$rose(o_ack) && $past(sel_q) |-> state != st_idle;
	endproperty
	a_ack_consumes_word: assert property (p_ack_consumes_word)
		else $error("acknowledged word was not taken by the session FSM");

	// attenuation moves only just after a strobe rise under select
	property p_att_on_word;
		@(posedge clk) disable iff (resetd)
		$changed(o_vol_att) |->
			$past(i_host.sel, 2) && $past(i_host.strobe, 2) && !$past(i_host.strobe, 3);
	endproperty
	a_att_on_word: assert property (p_att_on_word)
		else $error("attenuation changed without a host word in a session");

endmodule

`default_nettype wire

// ==== source/hps_audio_pkg.sv ====
/*
 * hps_audio shared types
 * sample, host bus, command and mixer configuration definitions
 * used by the decoder, the channel mixers and the top level
 */
`default_nettype none

package hps_audio_pkg;

	//////////////////////////////////////////////////
	// sample and word widths
	//////////////////////////////////////////////////

	// one audio sample as it enters or leaves a mixer
	typedef logic [15:0] sample_t;

	// intermediate mixer value, one guard bit above a sample
	typedef logic signed [16:0] wide_sample_t;

	// data word on the host port
	typedef logic [15:0] host_word_t;

	// command byte, low byte of the first word in a session
	typedef logic [7:0] host_cmd_t;

	// bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] vol_att_t;

	// stereo blend of the other channel
	typedef enum logic [1:0] {
		mix_none   = 2'd0,
		mix_light  = 2'd1,
		mix_medium = 2'd2,
		mix_mono   = 2'd3
	} mix_mode_t;

	//////////////////////////////////////////////////
	// grouped signals
	//////////////////////////////////////////////////

	// settings shared by both channel mixers
	typedef struct packed {
		vol_att_t  att;
		mix_mode_t mix;
		logic      core_signed;
	} audio_cfg_t;

	// host port: session select, toggling strobe level, data word
	typedef struct packed {
		logic       sel;
		logic       strobe;
		host_word_t data;
	} host_bus_t;

	// volume attenuation command
	localparam host_cmd_t CMD_VOLUME = 8'h26;

	// equal consecutive core samples before one is taken
	localparam int STABLE_DEPTH_DEFAULT = 2;

endpackage

`default_nettype wire

// ==== source/hps_audio_top.sv ====
/*
 * hps_audio top level
 * host command decoder plus cross-coupled left and right channel mixers
 */
`timescale 1ns/1ps
`default_nettype none

module hps_audio_top #(
	parameter int STABLE_DEPTH = hps_audio_pkg::STABLE_DEPTH_DEFAULT
) (
	input  wire                            clk,
	input  wire                            resetd,
	input  wire  hps_audio_pkg::host_bus_t i_host,
	output logic                           o_host_ack,
	input  wire  hps_audio_pkg::sample_t   i_core_left,
	input  wire  hps_audio_pkg::sample_t   i_core_right,
	input  wire                            i_core_signed,
	input  wire  hps_audio_pkg::mix_mode_t i_mix,
	input  wire  hps_audio_pkg::sample_t   i_pcm_left,
	input  wire  hps_audio_pkg::sample_t   i_pcm_right,
	output hps_audio_pkg::sample_t         o_audio_left,
	output hps_audio_pkg::sample_t         o_audio_right
);

	import hps_audio_pkg::*;

	vol_att_t   vol_att;
	audio_cfg_t cfg;
	sample_t    pre_left;
	sample_t    pre_right;

	host_cmd_decoder u_decoder (
		.clk       (clk),
		.resetd    (resetd),
		.i_host    (i_host),
		.o_ack     (o_host_ack),
		.o_vol_att (vol_att)
	);

	// same settings go to both channels
	assign cfg = '{att: vol_att, mix: i_mix, core_signed: i_core_signed};

	//////////////////////////////////////////////////
	// channel mixers, each fed the other's pre-mix
	//////////////////////////////////////////////////

	audio_channel_mixer #(
		.STABLE_DEPTH (STABLE_DEPTH)
	) u_mix_left (
		.clk         (clk),
		.resetd      (resetd),
		.i_cfg       (cfg),
		.i_core      (i_core_left),
		.i_pcm       (i_pcm_left),
		.i_pre_other (pre_right),
		.o_pre       (pre_left),
		.o_audio     (o_audio_left)
	);

	audio_channel_mixer #(
		.STABLE_DEPTH (STABLE_DEPTH)
	) u_mix_right (
		.clk         (clk),
		.resetd      (resetd),
		.i_cfg       (cfg),
		.i_core      (i_core_right),
		.i_pcm       (i_pcm_right),
		.i_pre_other (pre_left),
		.o_pre       (pre_right),
		.o_audio     (o_audio_right)
	);

endmodule

`default_nettype wire

// ==== verif/tb_checker.sv ====
/*
 * testbench checker
 * steady-state model of both cross-coupled channels, compares the DUT
 * outputs and keeps the test and failure counts
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  wire        clk,
	input  wire        i_check_reset,
	input  wire        i_check_row,
	input  wire [31:0] i_row_idx,
	input  wire [15:0] i_vol,
	input  wire [1:0]  i_kind,
	input  wire [1:0]  i_mix,
	input  wire        i_sgn,
	input  wire [15:0] i_core_l,
	input  wire [15:0] i_core_r,
	input  wire [15:0] i_pcm_l,
	input  wire [15:0] i_pcm_r,
	input  wire [15:0] i_audio_l,
	input  wire [15:0] i_audio_r,
	input  wire        i_ack,
	output int         o_tests,
	output int         o_fails
);

	// attenuation the DUT should hold, only a clean volume session moves it
	logic [4:0] att_model = 5'd0;

	// core sample after the signed/unsigned conversion
	function automatic int conv(logic [15:0] c, logic sgn);
		if (sgn) begin
			return int'($signed(c));
		end
		return int'({1'b0, c[15:1]});
	endfunction

	function automatic int blend(int sum, int other_pre, logic [1:0] mode);
		case (mode)
			2'd1: return sum - (sum >>> 3) + (other_pre >>> 2);
			2'd2: return sum - (sum >>> 2) + (other_pre >>> 1);
			2'd3: return (sum >>> 1) + other_pre;
			default: return sum;
		endcase
	endfunction

	function automatic int attenuate(int m, logic [4:0] att);
		if (att[4]) begin
			return 0;
		end
		return m >>> att[3:0];
	endfunction

	function automatic int clamp16(int v);
		if (v > 32767) begin
			return 32767;
		end
		if (v < -32768) begin
			return -32768;
		end
		return v;
	endfunction

	initial begin
		o_tests = 0;
		o_fails = 0;
	end

	task automatic check_reset_state();
		o_tests++;
		if (i_audio_l != 16'h0 || i_audio_r != 16'h0 || i_ack != 1'b0) begin
			o_fails++;
			$display("Fail at %0t: after reset left %h right %h ack %b, expected zeros",
				$time, i_audio_l, i_audio_r, i_ack);
		end else begin
			$display("reset state ok");
		end
	endtask

	task automatic check_row();
		int sum_l;
		int sum_r;
		int exp_l;
		int exp_r;
		if (i_kind == 2'd0) begin
			att_model = i_vol[4:0];
		end
		sum_l = conv(i_core_l, i_sgn) + int'($signed(i_pcm_l));
		sum_r = conv(i_core_r, i_sgn) + int'($signed(i_pcm_r));
		// each pre-mix value is half of its own sum
		exp_l = clamp16(attenuate(blend(sum_l, sum_r >>> 1, i_mix), att_model));
		exp_r = clamp16(attenuate(blend(sum_r, sum_l >>> 1, i_mix), att_model));
		o_tests++;
		if (int'($signed(i_audio_l)) != exp_l || int'($signed(i_audio_r)) != exp_r) begin
			o_fails++;
			$display("Fail at %0t: row %0d left %h right %h, expected %h %h",
				$time, i_row_idx, i_audio_l, i_audio_r, exp_l[15:0], exp_r[15:0]);
		end else begin
			$display("row %0d ok: att %h mix %0d left %h right %h",
				i_row_idx, att_model, i_mix, i_audio_l, i_audio_r);
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (i_check_reset) begin
			check_reset_state();
		end
		if (i_check_row) begin
			check_row();
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
/*
 * testbench clock and reset source
 * 40 ns clock, resetd held high for the first 8 rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter time PERIOD      = 40ns,
	parameter int  RESET_TICKS = 8
) (
	output logic clk,
	output logic resetd
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		resetd = 1'b1;
		repeat (RESET_TICKS) @(posedge clk);
		#2 resetd = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/tb_hps_audio.sv ====
/*
 * hps_audio testbench
 * applies a table of volume sessions and samples, random rows from an LFSR
 */
`timescale 1ns/1ps
`default_nettype none

module tb_hps_audio;

	import hps_audio_pkg::*;

	localparam int TABLE_SIZE   = 40;
	localparam int ACK_TIMEOUT  = 50;
	localparam int HOLD_CYCLES  = 20;
	localparam int RANDOM_ROWS  = 10;
	localparam logic [31:0] LFSR_SEED = 32'h0fac95ff;

	logic       clk;
	logic       resetd;
	host_bus_t  host;
	logic       host_ack;
	sample_t    core_l;
	sample_t    core_r;
	sample_t    pcm_l;
	sample_t    pcm_r;
	sample_t    audio_l;
	sample_t    audio_r;
	logic       core_sgn;
	mix_mode_t  mix;
	host_word_t vol;
	logic [1:0] kind;
	logic [31:0] row_idx;
	logic       check_reset;
	logic       check_row;
	int         tests;
	int         fails;
	int         timeouts;
	int         row_count;
	logic [31:0] lfsr;

	// kind 0 clean volume session, 1 wrong command, 2 select dropped
	typedef struct packed {
		host_word_t vol;
		logic [1:0] kind;
		logic [1:0] mix;
		logic       sgn;
		sample_t    core_l;
		sample_t    core_r;
		sample_t    pcm_l;
		sample_t    pcm_r;
	} test_row_t;

	test_row_t rows [0:TABLE_SIZE-1];

	tb_clock_gen u_clock (.clk(clk), .resetd(resetd));

	hps_audio_top #(.STABLE_DEPTH(STABLE_DEPTH_DEFAULT)) UUT (
		.clk (clk), .resetd (resetd),
		.i_host (host), .o_host_ack (host_ack),
		.i_core_left (core_l), .i_core_right (core_r),
		.i_core_signed (core_sgn), .i_mix (mix),
		.i_pcm_left (pcm_l), .i_pcm_right (pcm_r),
		.o_audio_left (audio_l), .o_audio_right (audio_r)
	);

	tb_checker u_checker (
		.clk (clk), .i_check_reset (check_reset), .i_check_row (check_row),
		.i_row_idx (row_idx), .i_vol (vol), .i_kind (kind), .i_mix (mix),
		.i_sgn (core_sgn), .i_core_l (core_l), .i_core_r (core_r),
		.i_pcm_l (pcm_l), .i_pcm_r (pcm_r), .i_audio_l (audio_l),
		.i_audio_r (audio_r), .i_ack (host_ack), .o_tests (tests), .o_fails (fails)
	);

	//////////////////////////////////////////////////
	// random source
	//////////////////////////////////////////////////

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic add_row(input host_word_t v, input logic [1:0] k, input logic [1:0] m,
			input logic s, input sample_t cl, input sample_t cr, input sample_t pl,
			input sample_t pr);
		rows[row_count] = '{vol: v, kind: k, mix: m, sgn: s, core_l: cl, core_r: cr,
			pcm_l: pl, pcm_r: pr};
		row_count++;
	endtask

	task automatic build_table();
		logic [15:0] r [0:6];
		for (int k = 0; k < 16; k++) begin
			add_row(16'(k), 2'd0, 2'd0, 1'b1, 16'h1234, 16'he000, 16'h0100, 16'hff00);
		end
		add_row(16'h0010, 2'd0, 2'd0, 1'b1, 16'h7000, 16'h9000, 16'h1000, 16'hf000);
		add_row(16'hff1f, 2'd0, 2'd3, 1'b0, 16'hffff, 16'h8001, 16'h7fff, 16'h8000);
		add_row(16'h0000, 2'd0, 2'd0, 1'b0, 16'h8000, 16'hc000, 16'h0000, 16'h0010);
		add_row(16'h0001, 2'd0, 2'd0, 1'b0, 16'hfffe, 16'h0003, 16'hfc00, 16'h0200);
		add_row(16'h0000, 2'd0, 2'd1, 1'b1, 16'h2000, 16'hd000, 16'h0400, 16'h0100);
		add_row(16'h0002, 2'd0, 2'd2, 1'b1, 16'h6000, 16'h1000, 16'h1000, 16'hfff0);
		add_row(16'h0000, 2'd0, 2'd3, 1'b1, 16'h4000, 16'hc000, 16'h0100, 16'h0300);
		// full scale, mode 3 must clamp on both sides
		add_row(16'h0000, 2'd0, 2'd3, 1'b1, 16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff);
		add_row(16'h0000, 2'd0, 2'd3, 1'b1, 16'h8000, 16'h8000, 16'h8000, 16'h8000);
		// attenuation must stay 0 through these two
		add_row(16'h0003, 2'd1, 2'd0, 1'b1, 16'h0400, 16'h0800, 16'h0010, 16'h0020);
		add_row(16'h0005, 2'd2, 2'd0, 1'b1, 16'h0400, 16'h0800, 16'h0010, 16'h0020);
		for (int n = 0; n < RANDOM_ROWS; n++) begin
			take_bits(5, r[0]);
			take_bits(2, r[1]);
			take_bits(1, r[2]);
			take_bits(16, r[3]);
			take_bits(16, r[4]);
			take_bits(16, r[5]);
			take_bits(16, r[6]);
			add_row(r[0], 2'd0, r[1][1:0], r[2][0], r[3], r[4], r[5], r[6]);
		end
	endtask

	//////////////////////////////////////////////////
	// host port driver
	//////////////////////////////////////////////////

	task automatic wait_ack(input logic level);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < ACK_TIMEOUT && !seen; n++) begin
			@(negedge clk);
			seen = (host_ack == level);
		end
		if (!seen) begin
			$display("timeout: host acknowledge did not reach %b at %0t", level, $time);
			timeouts++;
		end
	endtask

	task automatic send_word(input host_word_t w);
		@(posedge clk);
		#2 host.data = w;
		@(posedge clk);
		#2 host.strobe = 1'b1;
		wait_ack(1'b1);
		@(posedge clk);
		#2 host.strobe = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic set_select(input logic v);
		@(posedge clk);
		#2 host.sel = v;
		repeat (2) @(posedge clk);
	endtask

	task automatic volume_session(input host_word_t v, input logic [1:0] k);
		set_select(1'b1);
		send_word({8'h00, (k == 2'd1) ? 8'h25 : CMD_VOLUME});
		if (k == 2'd2) begin
			set_select(1'b0);
			set_select(1'b1);
		end
		send_word(v);
		set_select(1'b0);
	endtask

	task automatic apply_row(input int r);
		@(posedge clk);
		#2;
		row_idx  = 32'(r);
		vol      = rows[r].vol;
		kind     = rows[r].kind;
		mix      = mix_mode_t'(rows[r].mix);
		core_sgn = rows[r].sgn;
		core_l   = rows[r].core_l;
		core_r   = rows[r].core_r;
		pcm_l    = rows[r].pcm_l;
		pcm_r    = rows[r].pcm_r;
		volume_session(rows[r].vol, rows[r].kind);
		repeat (HOLD_CYCLES) @(posedge clk);
		#2 check_row = 1'b1;
		@(posedge clk);
		#2 check_row = 1'b0;
	endtask

	task automatic wait_reset_release();
		logic released;
		released = 1'b0;
		for (int n = 0; n < 20 && !released; n++) begin
			@(negedge clk);
			released = !resetd;
		end
		if (!released) begin
			$display("reset was never released");
			timeouts++;
		end
	endtask

	initial begin
		// busy inputs while reset is held
		host = '{sel: 1'b0, strobe: 1'b1, data: 16'h5a5a};
		core_l = 16'h1357;
		core_r = 16'h8642;
		pcm_l = 16'h0321;
		pcm_r = 16'hfedc;
		core_sgn = 1'b1;
		mix = mix_mono;
		vol = '0;
		kind = 2'd0;
		row_idx = '0;
		check_reset = 1'b0;
		check_row = 1'b0;
		timeouts = 0;
		row_count = 0;
		lfsr = LFSR_SEED;
		build_table();
		wait_reset_release();
		@(posedge clk);
		#2 check_reset = 1'b1;
		@(posedge clk);
		#2 check_reset = 1'b0;
		host.strobe = 1'b0;
		wait_ack(1'b0);
		for (int r = 0; r < row_count; r++) begin
			apply_row(r);
		end
		@(posedge clk);
		$display("%0d tests, %0d failed, %0d timeouts", tests, fails, timeouts);
		if (fails == 0 && timeouts == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
